// ==== all.f ====
fpu_mv_pkg.sv
fpu_mv_decoder.sv
fpu_mv_operand_fetch.sv
fpu_mv_exec.sv
fpu_mv_pipe.sv
fpu_mv_pipe_properties.sv
tb_fpu_mv_pipe.sv

// ==== fpu_mv_decoder.sv ====
// Combinational ex0 decoder, maps an OP-FP instruction word to a move/sign-injection op
`default_nettype none
`timescale 1ns/1ps

module fpu_mv_decoder (
  input  logic [31:0]         i_inst,
  output fpu_mv_pkg::fpu_op_e o_op
);

  localparam logic [6:0] OPC_OP_FP = 7'b1010011;

  logic [6:0] w_opcode;
  logic [4:0] w_rs2;
  logic [9:0] w_key;

  assign w_opcode = i_inst[6:0];
  assign w_rs2    = i_inst[24:20];
  // funct7 and funct3 together
  assign w_key    = {i_inst[31:25], i_inst[14:12]};

  always_comb begin
    o_op = fpu_mv_pkg::OP_ILLEGAL;
    if (w_opcode == OPC_OP_FP) begin
      case (w_key)
        10'b0010000_000: o_op = fpu_mv_pkg::OP_FSGNJ_S;
        10'b0010000_001: o_op = fpu_mv_pkg::OP_FSGNJN_S;
        10'b0010000_010: o_op = fpu_mv_pkg::OP_FSGNJX_S;
        10'b0010001_000: o_op = fpu_mv_pkg::OP_FSGNJ_D;
        10'b0010001_001: o_op = fpu_mv_pkg::OP_FSGNJN_D;
        10'b0010001_010: o_op = fpu_mv_pkg::OP_FSGNJX_D;
        // Moves need rs2 == 0
        10'b1110000_000: if (w_rs2 == 5'd0) o_op = fpu_mv_pkg::OP_FMV_X_W;
        10'b1111000_000: if (w_rs2 == 5'd0) o_op = fpu_mv_pkg::OP_FMV_W_X;
        10'b1110001_000: if (w_rs2 == 5'd0) o_op = fpu_mv_pkg::OP_FMV_X_D;
        10'b1111001_000: if (w_rs2 == 5'd0) o_op = fpu_mv_pkg::OP_FMV_D_X;
        default: o_op = fpu_mv_pkg::OP_ILLEGAL;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== fpu_mv_exec.sv ====
// Combinational ex2 datapath for FP moves and sign injection, with NaN-box canonicalisation
`default_nettype none
`timescale 1ns/1ps

module fpu_mv_exec (
  input  fpu_mv_pkg::fpu_op_e i_op,
  input  fpu_mv_pkg::flen_t   i_rs1,
  input  fpu_mv_pkg::flen_t   i_rs2,
  output fpu_mv_pkg::flen_t   o_result
);

  localparam int MSB = fpu_mv_pkg::FLEN_W - 1;

  fpu_mv_pkg::flen_t w_rs1_box;
  fpu_mv_pkg::flen_t w_rs2_box;

  // Improperly boxed singles read as the canonical NaN
  assign w_rs1_box = (&i_rs1[MSB:32]) ? i_rs1 : fpu_mv_pkg::CANON_NAN_S;
  assign w_rs2_box = (&i_rs2[MSB:32]) ? i_rs2 : fpu_mv_pkg::CANON_NAN_S;

  always_comb begin
    case (i_op)
      // ----------------------------------------------------------
      // Moves
      // ----------------------------------------------------------
      fpu_mv_pkg::OP_FMV_X_W: o_result = {{32{i_rs1[31]}}, i_rs1[31:0]};
      fpu_mv_pkg::OP_FMV_W_X: o_result = {{32{1'b1}}, i_rs1[31:0]};
      fpu_mv_pkg::OP_FMV_X_D: o_result = i_rs1;
      fpu_mv_pkg::OP_FMV_D_X: o_result = i_rs1;
      // ----------------------------------------------------------
      // Double sign injection
      // ----------------------------------------------------------
      fpu_mv_pkg::OP_FSGNJ_D:  o_result = {i_rs2[MSB], i_rs1[MSB-1:0]};
      fpu_mv_pkg::OP_FSGNJN_D: o_result = {~i_rs2[MSB], i_rs1[MSB-1:0]};
      fpu_mv_pkg::OP_FSGNJX_D: o_result = {i_rs1[MSB] ^ i_rs2[MSB], i_rs1[MSB-1:0]};
      // ----------------------------------------------------------
      // Single sign injection, sign on bit 31
      // ----------------------------------------------------------
      fpu_mv_pkg::OP_FSGNJ_S: begin
        o_result = {w_rs1_box[MSB:32], w_rs2_box[31], w_rs1_box[30:0]};
      end
      fpu_mv_pkg::OP_FSGNJN_S: begin
        o_result = {w_rs1_box[MSB:32], ~w_rs2_box[31], w_rs1_box[30:0]};
      end
      fpu_mv_pkg::OP_FSGNJX_S: begin
        o_result = {w_rs1_box[MSB:32], w_rs1_box[31] ^ w_rs2_box[31], w_rs1_box[30:0]};
      end
      // Illegal ops never write back
      default: o_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== fpu_mv_operand_fetch.sv ====
// ex1 register-read requests and bus snoop, ex2 operand capture with late forwarding override
`default_nettype none
`timescale 1ns/1ps

module fpu_mv_operand_fetch #(
  parameter int TGT_BUS_SIZE = 3
) (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  fpu_mv_pkg::issue_t  i_ex1_issue,
  input  fpu_mv_pkg::issue_t  i_ex2_issue,
  input  fpu_mv_pkg::phy_wr_t i_phy_wr [TGT_BUS_SIZE],
  input  fpu_mv_pkg::flen_t   i_fpr_rd_data_rs1,
  input  fpu_mv_pkg::flen_t   i_fpr_rd_data_rs2,
  input  fpu_mv_pkg::flen_t   i_gpr_rd_data_rs1,
  output fpu_mv_pkg::rd_req_t o_fpr_rd_rs1,
  output fpu_mv_pkg::rd_req_t o_fpr_rd_rs2,
  output fpu_mv_pkg::rd_req_t o_gpr_rd_rs1,
  output fpu_mv_pkg::flen_t   o_ex2_rs1,
  output fpu_mv_pkg::flen_t   o_ex2_rs2
);

  fpu_mv_pkg::reg_ref_t w_ex1_src [2];
  fpu_mv_pkg::reg_ref_t w_ex2_src [2];
  fpu_mv_pkg::flen_t    w_ex1_rf  [2];
  fpu_mv_pkg::flen_t    w_ex2_sel [2];

  // ----------------------------------------------------------
  // ex1 read requests
  // ----------------------------------------------------------
  assign o_fpr_rd_rs1.valid = i_ex1_issue.valid & i_ex1_issue.rs1.valid &
                              (i_ex1_issue.rs1.typ == fpu_mv_pkg::FPR);
  assign o_fpr_rd_rs1.rnid  = i_ex1_issue.rs1.rnid;
  assign o_fpr_rd_rs2.valid = i_ex1_issue.valid & i_ex1_issue.rs2.valid &
                              (i_ex1_issue.rs2.typ == fpu_mv_pkg::FPR);
  assign o_fpr_rd_rs2.rnid  = i_ex1_issue.rs2.rnid;
  assign o_gpr_rd_rs1.valid = i_ex1_issue.valid & i_ex1_issue.rs1.valid &
                              (i_ex1_issue.rs1.typ == fpu_mv_pkg::GPR);
  assign o_gpr_rd_rs1.rnid  = i_ex1_issue.rs1.rnid;

  assign w_ex1_src[0] = i_ex1_issue.rs1;
  assign w_ex1_src[1] = i_ex1_issue.rs2;
  assign w_ex2_src[0] = i_ex2_issue.rs1;
  assign w_ex2_src[1] = i_ex2_issue.rs2;

  // Only rs1 can come from the GPR file
  assign w_ex1_rf[0] = (i_ex1_issue.rs1.typ == fpu_mv_pkg::GPR) ? i_gpr_rd_data_rs1 :
                                                                  i_fpr_rd_data_rs1;
  assign w_ex1_rf[1] = i_fpr_rd_data_rs2;

  // ----------------------------------------------------------
  // Snoop, capture and override per source
  // ----------------------------------------------------------
  for (genvar s = 0; s < 2; s++) begin : g_src
    logic              w_ex1_hit;
    logic              w_ex2_hit;
    fpu_mv_pkg::flen_t w_ex1_fwd;
    fpu_mv_pkg::flen_t w_ex2_fwd;
    fpu_mv_pkg::flen_t r_ex2_data;

    always_comb begin
      w_ex1_hit = 1'b0;
      w_ex2_hit = 1'b0;
      w_ex1_fwd = '0;
      w_ex2_fwd = '0;
      for (int t = 0; t < TGT_BUS_SIZE; t++) begin
        if (fpu_mv_pkg::is_fwd_hit(w_ex1_src[s], i_phy_wr[t])) begin
          w_ex1_hit = 1'b1;
          w_ex1_fwd = w_ex1_fwd | i_phy_wr[t].data;
        end
        if (fpu_mv_pkg::is_fwd_hit(w_ex2_src[s], i_phy_wr[t])) begin
          w_ex2_hit = 1'b1;
          w_ex2_fwd = w_ex2_fwd | i_phy_wr[t].data;
        end
      end
    end

    always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_ex2_data <= '0;
      end else begin
        r_ex2_data <= w_ex1_hit ? w_ex1_fwd : w_ex1_rf[s];
      end
    end

    assign w_ex2_sel[s] = w_ex2_hit ? w_ex2_fwd : r_ex2_data;
  end

  assign o_ex2_rs1 = w_ex2_sel[0];
  assign o_ex2_rs2 = w_ex2_sel[1];

endmodule

`default_nettype wire

// ==== fpu_mv_pipe.sv ====
// Top of the four-stage FP move pipe, holds the stage registers and drives write-back and done
`default_nettype none
`timescale 1ns/1ps

module fpu_mv_pipe #(
  parameter int TGT_BUS_SIZE = 3
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_flush,
  input  fpu_mv_pkg::issue_t    i_issue,
  input  fpu_mv_pkg::phy_wr_t   i_phy_wr [TGT_BUS_SIZE],
  input  fpu_mv_pkg::flen_t     i_fpr_rd_data_rs1,
  input  fpu_mv_pkg::flen_t     i_fpr_rd_data_rs2,
  input  fpu_mv_pkg::flen_t     i_gpr_rd_data_rs1,
  output fpu_mv_pkg::rd_req_t   o_fpr_rd_rs1,
  output fpu_mv_pkg::rd_req_t   o_fpr_rd_rs2,
  output fpu_mv_pkg::rd_req_t   o_gpr_rd_rs1,
  output fpu_mv_pkg::early_wr_t o_early_wr,
  output fpu_mv_pkg::phy_wr_t   o_phy_wr,
  output fpu_mv_pkg::done_rpt_t o_done
);

  fpu_mv_pkg::fpu_op_e w_ex0_op;
  fpu_mv_pkg::issue_t  w_ex1_next;
  fpu_mv_pkg::issue_t  w_ex2_next;
  fpu_mv_pkg::issue_t  w_ex3_next;

  fpu_mv_pkg::issue_t  r_ex1_issue;
  fpu_mv_pkg::fpu_op_e r_ex1_op;
  fpu_mv_pkg::issue_t  r_ex2_issue;
  fpu_mv_pkg::fpu_op_e r_ex2_op;
  fpu_mv_pkg::issue_t  r_ex3_issue;
  fpu_mv_pkg::fpu_op_e r_ex3_op;

  fpu_mv_pkg::flen_t   w_ex2_rs1;
  fpu_mv_pkg::flen_t   w_ex2_rs2;
  fpu_mv_pkg::flen_t   w_ex2_res;
  fpu_mv_pkg::flen_t   r_ex3_res;

  logic                w_ex3_legal;

  // ----------------------------------------------------------
  // ex0
  // ----------------------------------------------------------
  fpu_mv_decoder u_decoder (
    .i_inst (i_issue.inst),
    .o_op   (w_ex0_op)
  );

  // Flush kills whatever sits in ex0..ex2 this cycle
  always_comb begin
    w_ex1_next       = i_issue;
    w_ex1_next.valid = i_issue.valid & ~i_flush;
    w_ex2_next       = r_ex1_issue;
    w_ex2_next.valid = r_ex1_issue.valid & ~i_flush;
    w_ex3_next       = r_ex2_issue;
    w_ex3_next.valid = r_ex2_issue.valid & ~i_flush;
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
      r_ex2_issue <= '0;
      r_ex3_issue <= '0;
      r_ex1_op    <= fpu_mv_pkg::OP_ILLEGAL;
      r_ex2_op    <= fpu_mv_pkg::OP_ILLEGAL;
      r_ex3_op    <= fpu_mv_pkg::OP_ILLEGAL;
    end else begin
      r_ex1_issue <= w_ex1_next;
      r_ex2_issue <= w_ex2_next;
      r_ex3_issue <= w_ex3_next;
      r_ex1_op    <= w_ex0_op;
      r_ex2_op    <= r_ex1_op;
      r_ex3_op    <= r_ex2_op;
    end
  end

  // ----------------------------------------------------------
  // ex1 / ex2
  // ----------------------------------------------------------
  assign o_early_wr.valid = r_ex1_issue.valid & r_ex1_issue.rd.valid &
                            (r_ex1_op != fpu_mv_pkg::OP_ILLEGAL);
  assign o_early_wr.typ   = r_ex1_issue.rd.typ;
  assign o_early_wr.rnid  = r_ex1_issue.rd.rnid;

  fpu_mv_operand_fetch #(
    .TGT_BUS_SIZE (TGT_BUS_SIZE)
  ) u_operand_fetch (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_ex1_issue       (r_ex1_issue),
    .i_ex2_issue       (r_ex2_issue),
    .i_phy_wr          (i_phy_wr),
    .i_fpr_rd_data_rs1 (i_fpr_rd_data_rs1),
    .i_fpr_rd_data_rs2 (i_fpr_rd_data_rs2),
    .i_gpr_rd_data_rs1 (i_gpr_rd_data_rs1),
    .o_fpr_rd_rs1      (o_fpr_rd_rs1),
    .o_fpr_rd_rs2      (o_fpr_rd_rs2),
    .o_gpr_rd_rs1      (o_gpr_rd_rs1),
    .o_ex2_rs1         (w_ex2_rs1),
    .o_ex2_rs2         (w_ex2_rs2)
  );

  fpu_mv_exec u_exec (
    .i_op     (r_ex2_op),
    .i_rs1    (w_ex2_rs1),
    .i_rs2    (w_ex2_rs2),
    .o_result (w_ex2_res)
  );

  always_ff @(posedge i_clk) begin
    r_ex3_res <= w_ex2_res;
  end

  // ----------------------------------------------------------
  // ex3 write-back and done
  // ----------------------------------------------------------
  assign w_ex3_legal = (r_ex3_op != fpu_mv_pkg::OP_ILLEGAL);

  assign o_phy_wr.valid = r_ex3_issue.valid & r_ex3_issue.rd.valid & w_ex3_legal;
  assign o_phy_wr.typ   = r_ex3_issue.rd.typ;
  assign o_phy_wr.rnid  = r_ex3_issue.rd.rnid;
  assign o_phy_wr.data  = r_ex3_res;

  assign o_done.valid  = r_ex3_issue.valid;
  assign o_done.tag    = r_ex3_issue.tag;
  assign o_done.except = ~w_ex3_legal;

endmodule

`default_nettype wire

// ==== fpu_mv_pipe_properties.sv ====
// Concurrent assertions on latency, reset and exception rules, bound into the FP move pipe
`default_nettype none
`timescale 1ns/1ps

module fpu_mv_pipe_properties (
  input logic                  i_clk,
  input logic                  i_reset_n,
  input logic                  i_flush,
  input fpu_mv_pkg::issue_t    i_issue,
  input fpu_mv_pkg::fpu_op_e   i_ex0_op,
  input fpu_mv_pkg::early_wr_t i_early_wr,
  input fpu_mv_pkg::phy_wr_t   i_wb,
  input fpu_mv_pkg::done_rpt_t i_done
);

  int fail_count = 0;

  // ------------------------------------------------------------
  // Exception and write-back
  // ------------------------------------------------------------
  // Illegal issue that survives the pipe reports an exception and never writes back
  a_no_wb_on_except: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (i_issue.valid && !i_flush && i_ex0_op == fpu_mv_pkg::OP_ILLEGAL) ##1 !i_flush ##1 !i_flush
      |=> i_done.valid && i_done.except && !i_wb.valid)
  else begin
    $error("illegal issue did not end in an exception report without write-back");
    fail_count++;
  end

  // Legal issue that survives three flush-free cycles completes with its tag
  a_done_latency: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (i_issue.valid && !i_flush && i_ex0_op != fpu_mv_pkg::OP_ILLEGAL) ##1 !i_flush ##1 !i_flush
      |=> i_done.valid && !i_done.except && i_done.tag == $past(i_issue.tag, 3))
  else begin
    $error("done report missing or wrong three cycles after a legal issue");
    fail_count++;
  end

  a_reset_quiet: assert property (
    @(posedge i_clk)
    !i_reset_n |-> !i_early_wr.valid && !i_wb.valid && !i_done.valid)
  else begin
    $error("output strobe active during reset");
    fail_count++;
  end

endmodule

`default_nettype wire

// ==== fpu_mv_pkg.sv ====
// Widths, types and the forwarding match shared by the RTL of the FP move pipe
`default_nettype none

package fpu_mv_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int FLEN_W = 64;
  localparam int RNID_W = 6;
  localparam int TAG_W  = 8;

  typedef logic [FLEN_W-1:0] flen_t;
  typedef logic [RNID_W-1:0] rnid_t;

  // Boxed canonical single-precision NaN
  localparam flen_t CANON_NAN_S = 64'hffff_ffff_7fc0_0000;

  // ----------------------------------------------------------
  // Enums
  // ----------------------------------------------------------
  typedef enum logic [0:0] {
    GPR = 1'b0,
    FPR = 1'b1
  } reg_typ_e;

  typedef enum logic [3:0] {
    OP_FMV_X_W,
    OP_FMV_W_X,
    OP_FMV_X_D,
    OP_FMV_D_X,
    OP_FSGNJ_S,
    OP_FSGNJN_S,
    OP_FSGNJX_S,
    OP_FSGNJ_D,
    OP_FSGNJN_D,
    OP_FSGNJX_D,
    OP_ILLEGAL
  } fpu_op_e;

  // ----------------------------------------------------------
  // Structs
  // ----------------------------------------------------------
  typedef struct packed {
    logic     valid;
    reg_typ_e typ;
    rnid_t    rnid;
  } reg_ref_t;

  typedef struct packed {
    logic             valid;
    logic [31:0]      inst;
    logic [TAG_W-1:0] tag;
    reg_ref_t         rs1;
    reg_ref_t         rs2;
    reg_ref_t         rd;
  } issue_t;

  typedef struct packed {
    logic     valid;
    reg_typ_e typ;
    rnid_t    rnid;
    flen_t    data;
  } phy_wr_t;

  typedef struct packed {
    logic     valid;
    reg_typ_e typ;
    rnid_t    rnid;
  } early_wr_t;

  typedef struct packed {
    logic  valid;
    rnid_t rnid;
  } rd_req_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    logic             except;
  } done_rpt_t;

  // x0 is hardwired, so a GPR id 0 source never takes bus data
  function automatic logic is_fwd_hit(reg_ref_t src, phy_wr_t wr);
    logic not_x0;
    not_x0 = (src.typ != GPR) || (src.rnid != '0);
    return src.valid & wr.valid & not_x0 & (src.typ == wr.typ) & (src.rnid == wr.rnid);
  endfunction

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the FP move pipe testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_fpu_mv_pipe -f all.f \
  || { echo "build failed"; exit 1; }

./obj_dir/Vtb_fpu_mv_pipe +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q -F '*** FAILED ***' sim.log && { echo "result: fail"; exit 1; } || echo "result: pass"

// ==== tb_fpu_mv_pipe.sv ====
// Testbench for the FP move pipe, drives issues and bus entries and checks results with assertions
`default_nettype none
`timescale 1ns/1ps

module tb_fpu_mv_pipe;

  localparam int TGT_BUS_SIZE = 3;
  // 40 cycles per test, six tests, plus reset
  localparam int TIMEOUT_CYCLES = 40 * 6 + 10;
  // FMV.X.W with a nonzero rs2 field
  localparam logic [31:0] ILLEGAL_INST = {7'h70, 5'd4, 5'd1, 3'd0, 5'd2, 7'h53};

  logic                  i_clk;
  logic                  i_reset_n;
  logic                  i_flush;
  fpu_mv_pkg::issue_t    i_issue;
  fpu_mv_pkg::phy_wr_t   i_phy_wr [TGT_BUS_SIZE];
  fpu_mv_pkg::flen_t     i_fpr_rd_data_rs1;
  fpu_mv_pkg::flen_t     i_fpr_rd_data_rs2;
  fpu_mv_pkg::flen_t     i_gpr_rd_data_rs1;
  fpu_mv_pkg::rd_req_t   o_fpr_rd_rs1;
  fpu_mv_pkg::rd_req_t   o_fpr_rd_rs2;
  fpu_mv_pkg::rd_req_t   o_gpr_rd_rs1;
  fpu_mv_pkg::early_wr_t o_early_wr;
  fpu_mv_pkg::phy_wr_t   o_phy_wr;
  fpu_mv_pkg::done_rpt_t o_done;

  fpu_mv_pkg::flen_t     fpr [64];
  fpu_mv_pkg::flen_t     gpr [64];
  logic [31:0]           lcg_state = 32'h20db;
  logic [7:0]            next_tag = 8'd0;
  int                    cycle_count = 0;
  int                    error_count = 0;
  int                    test_err_base;
  int                    test_count = 0;
  int                    failed_tests = 0;
  int                    total_errors;
  string                 test_name;
  fpu_mv_pkg::rnid_t     id_a;
  fpu_mv_pkg::rnid_t     id_b;
  fpu_mv_pkg::fpu_op_e   op;
  fpu_mv_pkg::phy_wr_t   fwd;

  fpu_mv_pkg::fpu_op_e d_ops [3] = '{fpu_mv_pkg::OP_FSGNJ_D, fpu_mv_pkg::OP_FSGNJN_D,
                                     fpu_mv_pkg::OP_FSGNJX_D};
  fpu_mv_pkg::fpu_op_e s_ops [3] = '{fpu_mv_pkg::OP_FSGNJ_S, fpu_mv_pkg::OP_FSGNJN_S,
                                     fpu_mv_pkg::OP_FSGNJX_S};
  fpu_mv_pkg::fpu_op_e mv_ops [4] = '{fpu_mv_pkg::OP_FMV_X_W, fpu_mv_pkg::OP_FMV_W_X,
                                      fpu_mv_pkg::OP_FMV_X_D, fpu_mv_pkg::OP_FMV_D_X};

  fpu_mv_pipe #(
    .TGT_BUS_SIZE (TGT_BUS_SIZE)
  ) fpu_mv_pipe_i (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_flush           (i_flush),
    .i_issue           (i_issue),
    .i_phy_wr          (i_phy_wr),
    .i_fpr_rd_data_rs1 (i_fpr_rd_data_rs1),
    .i_fpr_rd_data_rs2 (i_fpr_rd_data_rs2),
    .i_gpr_rd_data_rs1 (i_gpr_rd_data_rs1),
    .o_fpr_rd_rs1      (o_fpr_rd_rs1),
    .o_fpr_rd_rs2      (o_fpr_rd_rs2),
    .o_gpr_rd_rs1      (o_gpr_rd_rs1),
    .o_early_wr        (o_early_wr),
    .o_phy_wr          (o_phy_wr),
    .o_done            (o_done)
  );

  bind fpu_mv_pipe fpu_mv_pipe_properties fpu_mv_pipe_properties_i (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_flush    (i_flush),
    .i_issue    (i_issue),
    .i_ex0_op   (w_ex0_op),
    .i_early_wr (o_early_wr),
    .i_wb       (o_phy_wr),
    .i_done     (o_done)
  );

  // Register files answer in the same cycle
  assign i_fpr_rd_data_rs1 = fpr[o_fpr_rd_rs1.rnid];
  assign i_fpr_rd_data_rs2 = fpr[o_fpr_rd_rs2.rnid];
  assign i_gpr_rd_data_rs1 = gpr[o_gpr_rd_rs1.rnid];

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycle_count);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Random numbers and reference model
  // ------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic fpu_mv_pkg::flen_t rand64();
    return {next_rand(), next_rand()};
  endfunction

  function automatic fpu_mv_pkg::rnid_t rand_id();
    return fpu_mv_pkg::rnid_t'(32'd1 + next_rand() % 32'd63);
  endfunction

  function automatic fpu_mv_pkg::flen_t single_value(input logic boxed);
    fpu_mv_pkg::flen_t v;
    v = rand64();
    if (boxed) begin
      v[63:32] = 32'hffff_ffff;
    end else begin
      v[40] = 1'b0;
    end
    return v;
  endfunction

  function automatic fpu_mv_pkg::reg_ref_t make_ref(input logic valid,
      input fpu_mv_pkg::reg_typ_e typ, input fpu_mv_pkg::rnid_t id);
    fpu_mv_pkg::reg_ref_t r;
    r.valid = valid;
    r.typ   = typ;
    r.rnid  = id;
    return r;
  endfunction

  function automatic fpu_mv_pkg::phy_wr_t make_wr(input fpu_mv_pkg::reg_typ_e typ,
      input fpu_mv_pkg::rnid_t id, input fpu_mv_pkg::flen_t data);
    fpu_mv_pkg::phy_wr_t w;
    w.valid = 1'b1;
    w.typ   = typ;
    w.rnid  = id;
    w.data  = data;
    return w;
  endfunction

  // Instruction word with rs1 = 1, rd = 2
  function automatic logic [31:0] encode(input fpu_mv_pkg::fpu_op_e kind);
    logic [9:0] key;
    logic [4:0] rs2_f;
    case (kind)
      fpu_mv_pkg::OP_FSGNJ_S:  key = {7'h10, 3'd0};
      fpu_mv_pkg::OP_FSGNJN_S: key = {7'h10, 3'd1};
      fpu_mv_pkg::OP_FSGNJX_S: key = {7'h10, 3'd2};
      fpu_mv_pkg::OP_FSGNJ_D:  key = {7'h11, 3'd0};
      fpu_mv_pkg::OP_FSGNJN_D: key = {7'h11, 3'd1};
      fpu_mv_pkg::OP_FSGNJX_D: key = {7'h11, 3'd2};
      fpu_mv_pkg::OP_FMV_X_W:  key = {7'h70, 3'd0};
      fpu_mv_pkg::OP_FMV_W_X:  key = {7'h78, 3'd0};
      fpu_mv_pkg::OP_FMV_X_D:  key = {7'h71, 3'd0};
      fpu_mv_pkg::OP_FMV_D_X:  key = {7'h79, 3'd0};
      default:                 key = {7'h7f, 3'd7};
    endcase
    // Moves carry rs2 = 0
    rs2_f = (key[9:8] == 2'b11) ? 5'd0 : 5'd3;
    return {key[9:3], rs2_f, 5'd1, key[2:0], 5'd2, 7'h53};
  endfunction

  // Operand as the pipe should see it, bus hit first
  function automatic fpu_mv_pkg::flen_t source_value(input fpu_mv_pkg::reg_ref_t src,
      input int fwd_stage, input fpu_mv_pkg::phy_wr_t wr);
    logic hit;
    hit = (fwd_stage != 0) && wr.valid && src.valid && (src.typ == wr.typ) &&
          (src.rnid == wr.rnid) && !(src.typ == fpu_mv_pkg::GPR && src.rnid == 6'd0);
    if (hit) begin
      return wr.data;
    end
    return (src.typ == fpu_mv_pkg::GPR) ? gpr[src.rnid] : fpr[src.rnid];
  endfunction

  function automatic fpu_mv_pkg::flen_t model_result(input fpu_mv_pkg::fpu_op_e kind,
      input fpu_mv_pkg::flen_t a, input fpu_mv_pkg::flen_t b);
    fpu_mv_pkg::flen_t r;
    fpu_mv_pkg::flen_t sa;
    fpu_mv_pkg::flen_t sb;
    sa = (a[63:32] == 32'hffff_ffff) ? a : 64'hffff_ffff_7fc0_0000;
    sb = (b[63:32] == 32'hffff_ffff) ? b : 64'hffff_ffff_7fc0_0000;
    r  = a;
    case (kind)
      fpu_mv_pkg::OP_FMV_X_W:  r = 64'($signed(a[31:0]));
      fpu_mv_pkg::OP_FMV_W_X:  r = {32'hffff_ffff, a[31:0]};
      fpu_mv_pkg::OP_FSGNJ_D:  r[63] = b[63];
      fpu_mv_pkg::OP_FSGNJN_D: r[63] = ~b[63];
      fpu_mv_pkg::OP_FSGNJX_D: r[63] = a[63] ^ b[63];
      fpu_mv_pkg::OP_FSGNJ_S, fpu_mv_pkg::OP_FSGNJN_S, fpu_mv_pkg::OP_FSGNJX_S: begin
        r = sa;
        if (kind == fpu_mv_pkg::OP_FSGNJ_S) begin
          r[31] = sb[31];
        end else if (kind == fpu_mv_pkg::OP_FSGNJN_S) begin
          r[31] = ~sb[31];
        end else begin
          r[31] = sa[31] ^ sb[31];
        end
      end
      default: r = a;
    endcase
    return r;
  endfunction

  // ------------------------------------------------------------
  // Checks and test bookkeeping
  // ------------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp)
      else begin
        $display("mismatch %s: got %h, expected %h", name, got, exp);
        error_count++;
      end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond)
      else begin
        $display("error: %s", what);
        error_count++;
      end
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    test_err_base = error_count;
  endtask

  task automatic end_test();
    test_count++;
    if (error_count != test_err_base) begin
      failed_tests++;
    end
    $display("test %0d %s: %s", test_count, test_name,
             (error_count == test_err_base) ? "ok" : "errors found");
  endtask

  // One instruction through the pipe, optional bus hit in ex1 or ex2
  task automatic send(input fpu_mv_pkg::fpu_op_e kind, input logic [31:0] inst,
                      input fpu_mv_pkg::reg_ref_t rs1, input fpu_mv_pkg::reg_ref_t rs2,
                      input fpu_mv_pkg::reg_ref_t rd, input int fwd_stage,
                      input fpu_mv_pkg::phy_wr_t wr, input logic kill);
    fpu_mv_pkg::issue_t iss;
    fpu_mv_pkg::flen_t  exp_res;
    logic               legal;
    int                 waited;
    legal     = (kind != fpu_mv_pkg::OP_ILLEGAL);
    exp_res   = model_result(kind, source_value(rs1, fwd_stage, wr),
                             source_value(rs2, fwd_stage, wr));
    iss       = '0;
    iss.valid = 1'b1;
    iss.inst  = inst;
    iss.tag   = next_tag;
    iss.rs1   = rs1;
    iss.rs2   = rs2;
    iss.rd    = rd;
    next_tag++;
    @(posedge i_clk);
    i_issue <= iss;
    // ex1
    @(posedge i_clk);
    i_issue <= '0;
    i_flush <= kill;
    if (fwd_stage == 1) begin
      i_phy_wr[0] <= wr;
    end
    @(negedge i_clk);
    check_value("o_early_wr.valid", 64'(o_early_wr.valid), 64'(legal && rd.valid));
    if (legal && rd.valid) begin
      check_value("o_early_wr.typ", 64'(o_early_wr.typ), 64'(rd.typ));
      check_value("o_early_wr.rnid", 64'(o_early_wr.rnid), 64'(rd.rnid));
    end
    check_value("o_gpr_rd_rs1.valid", 64'(o_gpr_rd_rs1.valid),
                64'(rs1.valid && rs1.typ == fpu_mv_pkg::GPR));
    check_value("o_fpr_rd_rs1.valid", 64'(o_fpr_rd_rs1.valid),
                64'(rs1.valid && rs1.typ == fpu_mv_pkg::FPR));
    check_value("o_fpr_rd_rs2.valid", 64'(o_fpr_rd_rs2.valid),
                64'(rs2.valid && rs2.typ == fpu_mv_pkg::FPR));
    // ex2
    @(posedge i_clk);
    i_flush <= 1'b0;
    if (fwd_stage == 2) begin
      i_phy_wr[0] <= wr;
    end else begin
      i_phy_wr[0] <= '0;
    end
    @(posedge i_clk);
    i_phy_wr[0] <= '0;
    waited = 0;
    @(negedge i_clk);
    while (!o_done.valid && waited < 4) begin
      @(negedge i_clk);
      waited++;
    end
    if (kill) begin
      check_true(!o_done.valid, "flushed instruction produced a done report");
    end else begin
      check_true(o_done.valid, "no done report arrived for the issued instruction");
      check_value("o_done.tag", 64'(o_done.tag), 64'(iss.tag));
      check_value("o_done.except", 64'(o_done.except), 64'(!legal));
      check_value("o_phy_wr.valid", 64'(o_phy_wr.valid), 64'(legal && rd.valid));
      if (legal) begin
        check_value("o_phy_wr.data", o_phy_wr.data, exp_res);
        check_value("o_phy_wr.typ", 64'(o_phy_wr.typ), 64'(rd.typ));
        check_value("o_phy_wr.rnid", 64'(o_phy_wr.rnid), 64'(rd.rnid));
      end
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin
    i_reset_n <= 1'b0;
    i_flush   <= 1'b0;
    i_issue   <= '0;
    for (int i = 0; i < TGT_BUS_SIZE; i++) begin
      i_phy_wr[i] <= '0;
    end
    for (int i = 0; i < 64; i++) begin
      fpr[i] = rand64();
      gpr[i] = rand64();
    end
    gpr[0] = '0;
    repeat (10) @(posedge i_clk);
    i_reset_n <= 1'b1;

    start_test("idle after reset");
    repeat (10) begin
      @(negedge i_clk);
      check_true(!o_early_wr.valid && !o_phy_wr.valid && !o_done.valid,
                 "output strobe active while the pipe is idle");
    end
    end_test();

    start_test("double sign injection");
    for (int k = 0; k < 6; k++) begin
      id_a      = rand_id();
      id_b      = rand_id();
      fpr[id_a] = rand64();
      fpr[id_b] = rand64();
      send(d_ops[k % 3], encode(d_ops[k % 3]), make_ref(1'b1, fpu_mv_pkg::FPR, id_a),
           make_ref(1'b1, fpu_mv_pkg::FPR, id_b), make_ref(1'b1, fpu_mv_pkg::FPR, rand_id()),
           0, '0, 1'b0);
    end
    end_test();

    start_test("single sign injection and NaN boxing");
    for (int k = 0; k < 6; k++) begin
      id_a      = rand_id();
      id_b      = rand_id();
      fpr[id_b] = single_value(k != 4 && k != 5);
      fpr[id_a] = single_value(k != 3 && k != 5);
      send(s_ops[k % 3], encode(s_ops[k % 3]), make_ref(1'b1, fpu_mv_pkg::FPR, id_a),
           make_ref(1'b1, fpu_mv_pkg::FPR, id_b), make_ref(1'b1, fpu_mv_pkg::FPR, rand_id()),
           0, '0, 1'b0);
    end
    end_test();

    start_test("moves");
    for (int k = 0; k < 4; k++) begin
      op   = mv_ops[k];
      id_a = rand_id();
      if (op == fpu_mv_pkg::OP_FMV_W_X || op == fpu_mv_pkg::OP_FMV_D_X) begin
        gpr[id_a] = rand64();
        send(op, encode(op), make_ref(1'b1, fpu_mv_pkg::GPR, id_a),
             make_ref(1'b0, fpu_mv_pkg::FPR, 6'd0),
             make_ref(1'b1, fpu_mv_pkg::FPR, rand_id()), 0, '0, 1'b0);
      end else begin
        fpr[id_a] = rand64();
        send(op, encode(op), make_ref(1'b1, fpu_mv_pkg::FPR, id_a),
             make_ref(1'b0, fpu_mv_pkg::FPR, 6'd0),
             make_ref(1'b1, fpu_mv_pkg::GPR, rand_id()), 0, '0, 1'b0);
      end
    end
    end_test();

    start_test("forwarding");
    id_a = rand_id();
    id_b = rand_id();
    fwd  = make_wr(fpu_mv_pkg::FPR, id_a, rand64());
    send(fpu_mv_pkg::OP_FSGNJ_D, encode(fpu_mv_pkg::OP_FSGNJ_D),
         make_ref(1'b1, fpu_mv_pkg::FPR, id_a), make_ref(1'b1, fpu_mv_pkg::FPR, id_b),
         make_ref(1'b1, fpu_mv_pkg::FPR, rand_id()), 1, fwd, 1'b0);
    fwd = make_wr(fpu_mv_pkg::FPR, id_a, rand64());
    send(fpu_mv_pkg::OP_FSGNJN_D, encode(fpu_mv_pkg::OP_FSGNJN_D),
         make_ref(1'b1, fpu_mv_pkg::FPR, id_a), make_ref(1'b1, fpu_mv_pkg::FPR, id_b),
         make_ref(1'b1, fpu_mv_pkg::FPR, rand_id()), 2, fwd, 1'b0);
    // x0 on the bus must be ignored
    fwd = make_wr(fpu_mv_pkg::GPR, 6'd0, rand64());
    send(fpu_mv_pkg::OP_FMV_D_X, encode(fpu_mv_pkg::OP_FMV_D_X),
         make_ref(1'b1, fpu_mv_pkg::GPR, 6'd0), make_ref(1'b0, fpu_mv_pkg::FPR, 6'd0),
         make_ref(1'b1, fpu_mv_pkg::FPR, rand_id()), 1, fwd, 1'b0);
    end_test();

    start_test("illegal encoding and flush");
    send(fpu_mv_pkg::OP_ILLEGAL, ILLEGAL_INST, make_ref(1'b1, fpu_mv_pkg::FPR, rand_id()),
         make_ref(1'b0, fpu_mv_pkg::FPR, 6'd0), make_ref(1'b1, fpu_mv_pkg::GPR, rand_id()),
         0, '0, 1'b0);
    send(fpu_mv_pkg::OP_FSGNJ_D, encode(fpu_mv_pkg::OP_FSGNJ_D),
         make_ref(1'b1, fpu_mv_pkg::FPR, rand_id()), make_ref(1'b1, fpu_mv_pkg::FPR, rand_id()),
         make_ref(1'b1, fpu_mv_pkg::FPR, rand_id()), 0, '0, 1'b1);
    end_test();

    total_errors = error_count + fpu_mv_pipe_i.fpu_mv_pipe_properties_i.fail_count;
    $display("tests %0d, failed tests %0d, check errors %0d, assertion failures %0d",
             test_count, failed_tests, error_count,
             fpu_mv_pipe_i.fpu_mv_pipe_properties_i.fail_count);
    if (total_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
